// File: hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // ======================================================================
    // Widths and counts
    // ======================================================================

    // Data path width
    localparam int xlen      = 32;
    // Functional units in the stage
    localparam int num_lanes = 3;
    // Reorder buffer tag width
    localparam int tag_w     = 5;

    // Operands, results and PCs
    typedef logic [xlen-1:0]  data_t;
    // Reorder buffer entry tag
    typedef logic [tag_w-1:0] tag_t;
    // ALU function select
    typedef logic [3:0]       alu_op_t;
    // Branch kind
    typedef logic [2:0]       branch_sel_t;

    // ======================================================================
    // Operation encodings
    // ======================================================================

    // ALU functions, codes 10 to 15 are reserved and give zero
    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_sll  = 4'd2;
    localparam alu_op_t alu_slt  = 4'd3;
    localparam alu_op_t alu_sltu = 4'd4;
    localparam alu_op_t alu_xor  = 4'd5;
    localparam alu_op_t alu_srl  = 4'd6;
    localparam alu_op_t alu_sra  = 4'd7;
    localparam alu_op_t alu_or   = 4'd8;
    localparam alu_op_t alu_and  = 4'd9;

    // Branch kinds, 1 to 5 are conditional
    localparam branch_sel_t br_none = 3'd0;
    localparam branch_sel_t br_beq  = 3'd1;
    localparam branch_sel_t br_bne  = 3'd2;
    localparam branch_sel_t br_blt  = 3'd3;
    localparam branch_sel_t br_bge  = 3'd4;
    localparam branch_sel_t br_bltu = 3'd5;
    localparam branch_sel_t br_jal  = 3'd6;
    localparam branch_sel_t br_jalr = 3'd7;

    // ======================================================================
    // Packets
    // ======================================================================

    // Micro-op from the reservation stations
    typedef struct packed {
        logic        valid;
        tag_t        tag;
        data_t       pc;
        data_t       data_a;
        data_t       data_b;
        alu_op_t     alu_op;
        branch_sel_t branch_sel;
        logic        pred_taken;
        data_t       pred_target;
        data_t       alt_pc;       // Non-predicted path from decode
        logic        is_link;      // Writes pc+4
        logic        is_mem;       // Address calculation
    } issue_pkt_t;

    // Common data bus broadcast slot
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t result;
        logic  mispredict;
        data_t correct_pc;
        logic  is_mem;
    } cdb_pkt_t;

    // Branch predictor training
    typedef struct packed {
        logic  valid;
        data_t pc;
        logic  taken;
    } pred_update_t;

    // Front-end redirect
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t pc;
    } redirect_t;

    // One element per lane
    typedef issue_pkt_t   [num_lanes-1:0] issue_vec_t;
    typedef cdb_pkt_t     [num_lanes-1:0] cdb_vec_t;
    typedef pred_update_t [num_lanes-1:0] pred_update_vec_t;

endpackage

`default_nettype wire

// File: hw/alu_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module alu_shifter import exec_pkg::*; (
    input  wire data_t   data_a,
    input  wire data_t   data_b,
    input  wire alu_op_t alu_op,
    output data_t        result,
    output logic         zero,
    output logic         negative,
    output logic         carry,
    output logic         overflow
);

    // Subtract mode for sub and both set-less-than forms
    logic            do_sub;
    // Second adder input after optional inversion
    data_t           b_eff;
    // Sum with carry out on top
    logic [xlen:0]   sum_full;
    data_t           sum;
    // Shift amount from the low five bits
    logic [4:0]      shamt;
    // Signed and unsigned less-than
    logic            lt_signed;
    logic            lt_unsigned;

    // ======================================================================
    // Shared adder-subtractor
    // ======================================================================

    assign do_sub = (alu_op == alu_sub) || (alu_op == alu_slt) || (alu_op == alu_sltu);

    // Two's complement subtract as a + ~b + 1
    assign b_eff    = do_sub ? ~data_b : data_b;
    assign sum_full = {1'b0, data_a} + {1'b0, b_eff} + {{xlen{1'b0}}, do_sub};
    assign sum      = sum_full[xlen-1:0];

    // Flags come from the adder whatever the selected function
    assign carry    = sum_full[xlen];
    assign zero     = (sum == '0);
    assign negative = sum[xlen-1];
    // Operands of equal sign giving a result of the other sign
    assign overflow = (data_a[xlen-1] == b_eff[xlen-1]) && (sum[xlen-1] != data_a[xlen-1]);

    // Compares reuse the subtract flags
    assign lt_signed   = negative ^ overflow;
    // No carry out of the subtract means a borrow
    assign lt_unsigned = ~carry;

    assign shamt = data_b[4:0];

    // ======================================================================
    // Function select
    // ======================================================================

    always_comb begin
        unique case (alu_op)
            alu_add, alu_sub: result = sum;
            alu_sll:          result = data_a << shamt;
            alu_slt:          result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:         result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:          result = data_a ^ data_b;
            alu_srl:          result = data_a >> shamt;
            // Arithmetic shift keeps the sign bit
            alu_sra:          result = data_t'($signed(data_a) >>> shamt);
            alu_or:           result = data_a | data_b;
            alu_and:          result = data_a & data_b;
            // Reserved codes
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/branch_resolver.sv
`timescale 1ns/1ns
`default_nettype none

module branch_resolver import exec_pkg::*; (
    input  wire branch_sel_t branch_sel,
    input  wire logic        zero,
    input  wire logic        negative,
    input  wire logic        carry,
    input  wire logic        overflow,
    input  wire data_t       alu_result,
    input  wire logic        pred_taken,
    input  wire data_t       pred_target,
    input  wire data_t       alt_pc,
    output logic             is_cond,
    output logic             taken,
    output logic             mispredict,
    output data_t            correct_pc
);

    // JALR target with the low two bits cleared
    data_t jalr_target;

    assign jalr_target = {alu_result[xlen-1:2], 2'b00};

    // Codes 1 to 5 are the conditional branches
    assign is_cond = (branch_sel >= br_beq) && (branch_sel <= br_bltu);

    always_comb begin
        taken      = 1'b0;
        mispredict = 1'b0;
        correct_pc = '0;
        unique case (branch_sel)
            br_beq:  taken = zero;
            br_bne:  taken = ~zero;
            br_blt:  taken = negative ^ overflow;
            br_bge:  taken = ~(negative ^ overflow);
            // Borrow out of the subtract
            br_bltu: taken = ~carry;
            // Target already fixed in decode so no check
            br_jal:  taken = 1'b1;
            br_jalr: taken = 1'b1;
            default: taken = 1'b0;
        endcase

        // Conditional direction check, recovery goes down the other path
        if (is_cond) begin
            mispredict = taken ^ pred_taken;
            correct_pc = alt_pc;
        end

        // Indirect jump checks the whole target
        if (branch_sel == br_jalr) begin
            mispredict = (jalr_target != pred_target);
            correct_pc = jalr_target;
        end
    end

endmodule

`default_nettype wire

// File: hw/exec_lane.sv
`timescale 1ns/1ns
`default_nettype none

module exec_lane import exec_pkg::*; (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire issue_pkt_t issue,
    output cdb_pkt_t        cdb,
    output pred_update_t    pred_update
);

    // ALU outputs
    data_t alu_result;
    logic  zero;
    logic  negative;
    logic  carry;
    logic  overflow;

    // Branch outcome
    logic  is_cond;
    logic  taken;
    logic  mispredict;
    data_t correct_pc;

    // Value written back on the CDB
    data_t link_pc;
    data_t lane_result;

    // Control registers
    logic  cdb_valid_q;
    logic  mispredict_q;
    logic  upd_valid_q;

    // Payload registers
    tag_t  tag_q;
    data_t result_q;
    data_t correct_pc_q;
    logic  is_mem_q;
    data_t upd_pc_q;
    logic  upd_taken_q;

    // ======================================================================
    // Datapath
    // ======================================================================

    alu_shifter u_alu_shifter (
        .data_a   (issue.data_a),
        .data_b   (issue.data_b),
        .alu_op   (issue.alu_op),
        .result   (alu_result),
        .zero     (zero),
        .negative (negative),
        .carry    (carry),
        .overflow (overflow)
    );

    branch_resolver u_branch_resolver (
        .branch_sel  (issue.branch_sel),
        .zero        (zero),
        .negative    (negative),
        .carry       (carry),
        .overflow    (overflow),
        .alu_result  (alu_result),
        .pred_taken  (issue.pred_taken),
        .pred_target (issue.pred_target),
        .alt_pc      (issue.alt_pc),
        .is_cond     (is_cond),
        .taken       (taken),
        .mispredict  (mispredict),
        .correct_pc  (correct_pc)
    );

    assign link_pc = issue.pc + data_t'(4);

    // Link wins, conditional branches write nothing useful
    assign lane_result = issue.is_link ? link_pc :
                         is_cond       ? '0      : alu_result;

    // ======================================================================
    // Output registers
    // ======================================================================

    // Strobes only live for one cycle after the issue
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cdb_valid_q  <= 1'b0;
            mispredict_q <= 1'b0;
            upd_valid_q  <= 1'b0;
        end else begin
            cdb_valid_q  <= issue.valid;
            mispredict_q <= issue.valid & mispredict;
            upd_valid_q  <= issue.valid & is_cond;
        end
    end

    // Capture payload with the micro-op
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            tag_q        <= issue.tag;
            result_q     <= lane_result;
            correct_pc_q <= correct_pc;
            is_mem_q     <= issue.is_mem;
            upd_pc_q     <= issue.pc;
            upd_taken_q  <= taken;
        end
    end

    assign cdb = '{valid:      cdb_valid_q,
                   tag:        tag_q,
                   result:     result_q,
                   mispredict: mispredict_q,
                   correct_pc: correct_pc_q,
                   is_mem:     is_mem_q};

    assign pred_update = '{valid: upd_valid_q,
                           pc:    upd_pc_q,
                           taken: upd_taken_q};

endmodule

`default_nettype wire

// File: hw/redirect_select.sv
`timescale 1ns/1ns
`default_nettype none

module redirect_select import exec_pkg::*; (
    input  wire cdb_vec_t cdb,
    output redirect_t     redirect
);

    // Lanes holding a valid mispredicted micro-op
    logic [num_lanes-1:0] hit;

    // ======================================================================
    // Lane scan
    // ======================================================================

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            hit[i] = cdb[i].valid & cdb[i].mispredict;
        end
    end

    // Lane 0 is the oldest in issue order
    // Walk from the top down so the lowest hit is written last
    always_comb begin
        redirect = '0;
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (hit[i]) begin
                redirect.valid = 1'b1;
                redirect.tag   = cdb[i].tag;
                redirect.pc    = cdb[i].correct_pc;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import exec_pkg::*; (
    input  wire logic             clk,
    input  wire logic             arst_n,
    // One micro-op slot per lane from the reservation stations
    input  wire issue_vec_t       issue,
    // Registered broadcast, one slot per lane
    output wire cdb_vec_t         cdb,
    // Predictor training, one slot per lane
    output wire pred_update_vec_t pred_update,
    // Single front-end redirect
    output wire redirect_t        redirect
);

    // ======================================================================
    // Functional unit lanes
    // ======================================================================

    // Identical single-cycle lanes
    // Each lane owns its CDB slot and predictor update slot
    genvar g;
    generate
        for (g = 0; g < num_lanes; g++) begin : g_lane
            exec_lane u_lane (
                .clk         (clk),
                .arst_n      (arst_n),
                .issue       (issue[g]),
                .cdb         (cdb[g]),
                .pred_update (pred_update[g])
            );
        end
    endgenerate

    // ======================================================================
    // Redirect
    // ======================================================================

    // Oldest mispredicting lane steers the front end
    // Valid in the same cycle as the CDB slots
    redirect_select u_redirect_select (
        .cdb      (cdb),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

// File: verification/execute_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage_tb import exec_pkg::*; ();

    // One directed micro-op with its expected outputs
    typedef struct packed {
        logic [7:0]   grp;
        logic [1:0]   lane;
        issue_pkt_t   pkt;
        cdb_pkt_t     cdb;
        pred_update_t upd;
        redirect_t    redir;
    } vec_rec_t;

    localparam int num_random = 40;

    logic             clk;
    logic             arst_n;
    issue_vec_t       issue;
    cdb_vec_t         cdb;
    pred_update_vec_t pred_update;
    redirect_t        redirect;

    // Stimulus and expectations for the cycle in progress
    issue_vec_t       stim;
    cdb_vec_t         exp_cdb;
    pred_update_vec_t exp_upd;
    redirect_t        exp_redir;

    vec_rec_t         vecs[$];
    integer           seed = 27;
    int               test_errs;
    int               pass_count;
    int               fail_count;
    logic             loaded;

    execute_stage i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue       (issue),
        .cdb         (cdb),
        .pred_update (pred_update),
        .redirect    (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==================================================================
    // Reference model and compare tasks
    // ==================================================================

    // RV32I semantics straight from the operation table
    function automatic data_t ref_alu(alu_op_t op, data_t a, data_t b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
            alu_sltu: return (a < b) ? data_t'(1) : data_t'(0);
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return data_t'($signed(a) >>> b[4:0]);
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return '0;
        endcase
    endfunction

    // Boundary values most of the time, a plain random word otherwise
    function automatic data_t pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'h8000_0000;
            3'd2:    return 32'h7fff_ffff;
            3'd3:    return 32'hffff_ffff;
            3'd4:    return 32'h0000_001f;
            default: return data_t'($random(seed));
        endcase
    endfunction

    task automatic compare_field(string name, data_t got, data_t exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            test_errs++;
        end
    endtask

    // Payload only matters when a valid is expected
    task automatic check_cdb(int lane, cdb_pkt_t got, cdb_pkt_t exp);
        compare_field($sformatf("cdb[%0d].valid", lane), got.valid, exp.valid);
        compare_field($sformatf("cdb[%0d].mispredict", lane), got.mispredict, exp.mispredict);
        if (exp.valid) begin
            compare_field($sformatf("cdb[%0d].tag", lane), got.tag, exp.tag);
            compare_field($sformatf("cdb[%0d].result", lane), got.result, exp.result);
            compare_field($sformatf("cdb[%0d].correct_pc", lane), got.correct_pc, exp.correct_pc);
            compare_field($sformatf("cdb[%0d].is_mem", lane), got.is_mem, exp.is_mem);
        end
    endtask

    task automatic check_pred(int lane, pred_update_t got, pred_update_t exp);
        compare_field($sformatf("pred_update[%0d].valid", lane), got.valid, exp.valid);
        if (exp.valid) begin
            compare_field($sformatf("pred_update[%0d].pc", lane), got.pc, exp.pc);
            compare_field($sformatf("pred_update[%0d].taken", lane), got.taken, exp.taken);
        end
    endtask

    task automatic check_redirect(redirect_t got, redirect_t exp);
        compare_field("redirect.valid", got.valid, exp.valid);
        if (exp.valid) begin
            compare_field("redirect.tag", got.tag, exp.tag);
            compare_field("redirect.pc", got.pc, exp.pc);
        end
    endtask

    // ==================================================================
    // Cycle driver
    // ==================================================================

    // Every output slot against the expectations, then one report line
    task automatic check_all_outputs(string name);
        for (int l = 0; l < num_lanes; l++) begin
            check_cdb(l, cdb[l], exp_cdb[l]);
            check_pred(l, pred_update[l], exp_upd[l]);
        end
        check_redirect(redirect, exp_redir);
        if (test_errs == 0) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s with %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    // Called on a falling edge, results land one cycle later
    task automatic issue_and_check(string name);
        issue = stim;
        @(negedge clk);
        check_all_outputs(name);
    endtask

    // ALU micro-ops on all lanes, never a branch
    task automatic build_random_cycle();
        logic [31:0] r;
        for (int l = 0; l < num_lanes; l++) begin
            r = $random(seed);
            stim[l]        = '0;
            stim[l].valid  = 1'b1;
            stim[l].tag    = r[4:0];
            stim[l].is_mem = r[8];
            stim[l].alu_op = r[15:12];
            stim[l].pc     = {r[31:16], 14'h0, 2'b00};
            stim[l].alt_pc = data_t'($random(seed));
            stim[l].data_a = pick_operand();
            stim[l].data_b = pick_operand();
            exp_cdb[l] = '{valid: 1'b1, tag: stim[l].tag,
                           result: ref_alu(stim[l].alu_op, stim[l].data_a, stim[l].data_b),
                           mispredict: 1'b0, correct_pc: '0, is_mem: stim[l].is_mem};
        end
        exp_upd   = '0;
        exp_redir = '0;
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin
        int          fd;
        int          i;
        int          j;
        string       line;
        logic [31:0] f [0:20];
        vec_rec_t    rec;
        issue    = '0;
        arst_n   = 1'b0;
        stim     = '0;
        loaded   = 1'b0;
        test_errs  = 0;
        pass_count = 0;
        fail_count = 0;

        fd = $fopen("verification/exec_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verification/exec_input.txt");
            $display("Simulation FAILED");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                            f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                            f[20]) != 21) begin
                    $display("Malformed stimulus line skipped: %s", line);
                    fail_count++;
                    continue;
                end
                rec.grp  = f[0][7:0];
                rec.lane = f[1][1:0];
                rec.pkt  = '{valid: 1'b1, tag: f[2][4:0], pc: f[3], data_a: f[4],
                             data_b: f[5], alu_op: f[6][3:0], branch_sel: f[7][2:0],
                             pred_taken: f[8][0], pred_target: f[9], alt_pc: f[10],
                             is_link: f[11][0], is_mem: f[12][0]};
                rec.cdb  = '{valid: 1'b1, tag: f[2][4:0], result: f[13],
                             mispredict: f[14][0], correct_pc: f[15], is_mem: f[12][0]};
                rec.upd   = '{valid: f[16][0], pc: f[3], taken: f[17][0]};
                rec.redir = '{valid: f[18][0], tag: f[19][4:0], pc: f[20]};
                vecs.push_back(rec);
            end
            $fclose(fd);
            loaded = 1'b1;

            // Mispredicting bne on every lane while reset is held
            for (int l = 0; l < num_lanes; l++) begin
                stim[l]            = '0;
                stim[l].valid      = 1'b1;
                stim[l].tag        = tag_t'(l + 1);
                stim[l].data_b     = data_t'(1);
                stim[l].alu_op     = alu_sub;
                stim[l].branch_sel = br_bne;
                stim[l].alt_pc     = data_t'(32'h40);
            end
            issue = stim;

            repeat (2) @(posedge clk);
            @(negedge clk);

            // Strobes must stay low under reset despite the busy issue
            exp_cdb   = '0;
            exp_upd   = '0;
            exp_redir = '0;
            check_all_outputs("reset state");
            arst_n = 1'b1;
            issue  = '0;
            stim   = '0;

            // Lines sharing a group number issue in the same cycle
            i = 0;
            while (i < vecs.size()) begin
                stim    = '0;
                exp_cdb = '0;
                exp_upd = '0;
                j = i;
                while (j < vecs.size() && vecs[j].grp == vecs[i].grp) begin
                    stim[vecs[j].lane]    = vecs[j].pkt;
                    exp_cdb[vecs[j].lane] = vecs[j].cdb;
                    exp_upd[vecs[j].lane] = vecs[j].upd;
                    j++;
                end
                exp_redir = vecs[j-1].redir;
                issue_and_check($sformatf("directed group %0d", vecs[i].grp));
                i = j;
            end

            for (int k = 0; k < num_random; k++) begin
                build_random_cycle();
                issue_and_check($sformatf("random cycle %0d", k));
            end
            issue = '0;

            $display("Tests passed %0d, failed %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

    // Four cycles of slack per test on top of reset
    initial begin
        longint timeout_ns;
        wait (loaded);
        timeout_ns = longint'(vecs.size() + num_random + 10) * 40 * 4;
        #(timeout_ns);
        $display("Run timed out after %0d ns without reaching the end", timeout_ns);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/exec_pkg.sv
hw/alu_shifter.sv
hw/branch_resolver.sv
hw/exec_lane.sv
hw/redirect_select.sv
hw/execute_stage.sv
verification/execute_stage_tb.sv

// File: verification/exec_input.txt
# issue: grp lane tag pc data_a data_b alu_op branch_sel pred_taken pred_target alt_pc link mem
# expect: result mispredict correct_pc upd_valid upd_taken redir_valid redir_tag redir_pc (hex)
1 0 01 1000 5 3 0 0 0 0 0 0 0 8 0 0 0 0 0 0 0
2 1 02 1004 3 5 1 0 0 0 0 0 0 fffffffe 0 0 0 0 0 0 0
3 2 03 1008 1 3f 2 0 0 0 0 0 0 80000000 0 0 0 0 0 0 0
4 0 04 100c 80000000 7fffffff 3 0 0 0 0 0 0 1 0 0 0 0 0 0 0
5 1 05 1010 80000000 7fffffff 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0
6 2 06 1014 80000000 1f 7 0 0 0 0 0 1 ffffffff 0 0 0 0 0 0 0
7 0 07 1018 80000000 1f 6 0 0 0 0 0 0 1 0 0 0 0 0 0 0
7 1 08 101c f0f0f0f0 ff00ff00 5 0 0 0 0 0 0 0ff00ff0 0 0 0 0 0 0 0
8 0 09 1020 12345678 1 f 0 0 0 0 0 0 0 0 0 0 0 0 0 0
8 1 0a 1024 f0f0f0f0 0f0f0000 8 0 0 0 0 0 0 fffff0f0 0 0 0 0 0 0 0
8 2 0b 1028 f0f0f0f0 ff00ff00 9 0 0 0 0 0 1 f000f000 0 0 0 0 0 0 0
9 0 0c 2000 5 5 1 1 1 0 2004 0 0 0 0 2004 1 1 0 0 0
10 0 0d 2004 5 6 1 2 0 0 2044 0 0 0 1 2044 1 1 1 0d 2044
11 0 0e 2008 fffffffe 1 1 3 0 0 2048 0 0 0 1 2048 1 1 1 0e 2048
12 1 0f 200c 80000000 7fffffff 1 4 1 0 2010 0 0 0 1 2010 1 0 1 0f 2010
13 2 10 2010 1 ffffffff 1 5 1 0 2014 0 0 0 0 2014 1 1 0 0 0
14 2 11 3000 3000 100 0 6 1 3100 3004 1 0 3004 0 0 0 0 0 0 0
15 0 12 3100 4001 2 0 7 1 4000 3104 1 0 3104 0 4000 0 0 0 0 0
16 1 13 3104 5000 7 0 7 1 4000 3108 1 0 3108 1 5004 0 0 1 13 5004
17 0 14 4000 1 1 0 0 0 0 0 0 0 2 0 0 0 0 1 15 4008
17 1 15 4004 1 2 1 1 1 0 4008 0 0 0 1 4008 1 0 1 15 4008
17 2 16 4008 6000 0 0 7 1 7000 400c 1 0 400c 1 6000 0 0 1 15 4008
18 0 17 5000 2 2 1 2 1 0 5004 0 0 0 1 5004 1 0 1 17 5004
18 1 18 5004 7 7 1 4 0 0 5040 0 0 0 1 5040 1 1 1 17 5004
18 2 19 5008 0 1 1 5 0 0 5048 0 0 0 1 5048 1 1 1 17 5004
